//--- mem_defines.svh
// **************************************************************************
// main memory size and timing macros
// **************************************************************************

`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// one stored word
`define MEM_WORD_W          32

// a cache line is four words
`define MEM_WORDS_PER_LINE  4
`define MEM_LINE_W          128

// lines held in the on-chip store
`define MEM_LINES           256

// byte address from the cache
// low 4 bits select a byte inside the line and are ignored
`define MEM_ADDR_W          12

// modeled response time of the memory in clock cycles
`define MEM_ACCESS_CYCLES   4

`endif

//--- mem_pkg.sv
// **************************************************************************
// main memory shared types
// **************************************************************************

`include "mem_defines.svh"

package mem_pkg;

    // full cache line as seen on the data ports
    typedef logic [`MEM_LINE_W-1:0] mem_line_t;

    // byte address from the cache
    typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;

    // line number inside the store
    // taken from the upper address bits
    typedef logic [$clog2(`MEM_LINES)-1:0] mem_line_idx_t;

    // request sequencer states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_ACK
    } mem_state_e;

    // operation latched at request time
    typedef enum logic {
        OP_READ,
        OP_WRITE
    } mem_op_e;

endpackage : mem_pkg

//--- mem_access_timer.sv
// **************************************************************************
// memory access latency timer
// **************************************************************************

`timescale 1ns/1ps

`include "mem_defines.svh"

module mem_access_timer (
    input  logic clk,
    input  logic rst,
    input  logic i_start,
    output logic o_done
);

    // wide enough to hold the full delay
    localparam int CNT_W = $clog2(`MEM_ACCESS_CYCLES + 1);

    logic [CNT_W-1:0] count_q;

    // zero means idle
    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
        end else if (i_start) begin
            count_q <= CNT_W'(`MEM_ACCESS_CYCLES);
        end else if (count_q != '0) begin
            count_q <= count_q - 1'b1;
        end
    end

    // last cycle of the delay
    // count drops to idle right after
    assign o_done = (count_q == CNT_W'(1));

endmodule : mem_access_timer

//--- mem_line_store.sv
// **************************************************************************
// main memory line store
// **************************************************************************

`timescale 1ns/1ps

`include "mem_defines.svh"

module mem_line_store (
    input  logic                    clk,

    // access strobes from the sequencer
    input  logic                    i_wr_stb,
    input  logic                    i_rd_stb,
    input  mem_pkg::mem_line_idx_t  i_line_idx,

    // line data
    input  mem_pkg::mem_line_t      i_w_data,
    output mem_pkg::mem_line_t      o_r_data
);

    // word select bits below the line index
    localparam int WORD_SEL_W = $clog2(`MEM_WORDS_PER_LINE);
    localparam int MEM_WORDS  = `MEM_LINES * `MEM_WORDS_PER_LINE;

    // word array
    // a line sits at four consecutive word addresses
    logic [`MEM_WORD_W-1:0] mem_q [MEM_WORDS];

    // whole line write on the strobe edge
    always_ff @(posedge clk) begin
        if (i_wr_stb) begin
            for (int w = 0; w < `MEM_WORDS_PER_LINE; w++) begin
                mem_q[{i_line_idx, WORD_SEL_W'(w)}] <= i_w_data[w*`MEM_WORD_W +: `MEM_WORD_W];
            end
        end
    end

    // registered line read
    // word 0 lands in the low bits
    // held until the next read strobe
    always_ff @(posedge clk) begin
        if (i_rd_stb) begin
            for (int w = 0; w < `MEM_WORDS_PER_LINE; w++) begin
                o_r_data[w*`MEM_WORD_W +: `MEM_WORD_W] <= mem_q[{i_line_idx, WORD_SEL_W'(w)}];
            end
        end
    end

endmodule : mem_line_store

//--- mem_cmd_fsm.sv
// **************************************************************************
// main memory request sequencer
// **************************************************************************

`timescale 1ns/1ps

`include "mem_defines.svh"

module mem_cmd_fsm (
    input  logic                    clk,
    input  logic                    rst,

    // cache request
    input  logic                    i_req,
    input  logic                    i_w_en,
    input  mem_pkg::mem_addr_t      i_addr,

    // latency timer
    input  logic                    i_timer_done,
    output logic                    o_timer_start,

    // line store control
    output logic                    o_wr_stb,
    output logic                    o_rd_stb,
    output mem_pkg::mem_line_idx_t  o_line_idx,

    // cache response
    output logic                    o_ack
);

    mem_pkg::mem_state_e    state_q;
    mem_pkg::mem_op_e       op_q;
    mem_pkg::mem_line_idx_t line_idx_q;
    logic                   accept;

    // new request only from idle
    // req is still high in the ack cycle so that cycle is masked
    assign accept = (state_q == mem_pkg::ST_IDLE) && i_req && !o_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q       <= mem_pkg::ST_IDLE;
            op_q          <= mem_pkg::OP_READ;
            o_timer_start <= 1'b0;
            o_ack         <= 1'b0;
        end else begin
            // single cycle pulses by default
            o_timer_start <= 1'b0;
            o_ack         <= 1'b0;
            case (state_q)
                mem_pkg::ST_IDLE: begin
                    if (accept) begin
                        if (i_w_en) begin
                            op_q <= mem_pkg::OP_WRITE;
                        end else begin
                            op_q <= mem_pkg::OP_READ;
                        end
                        o_timer_start <= 1'b1;
                        state_q       <= mem_pkg::ST_ACCESS;
                    end
                end
                mem_pkg::ST_ACCESS: begin
                    // store is strobed in this cycle
                    if (i_timer_done) begin
                        state_q <= mem_pkg::ST_ACK;
                    end
                end
                mem_pkg::ST_ACK: begin
                    o_ack   <= 1'b1;
                    state_q <= mem_pkg::ST_IDLE;
                end
                default: begin
                    state_q <= mem_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // line number from the upper address bits
    always_ff @(posedge clk) begin
        if (accept) begin
            line_idx_q <= i_addr[`MEM_ADDR_W-1 -: $bits(mem_pkg::mem_line_idx_t)];
        end
    end

    // one strobe when the delay is over
    assign o_wr_stb = (state_q == mem_pkg::ST_ACCESS) && i_timer_done &&
                      (op_q == mem_pkg::OP_WRITE);
    assign o_rd_stb = (state_q == mem_pkg::ST_ACCESS) && i_timer_done &&
                      (op_q == mem_pkg::OP_READ);

    assign o_line_idx = line_idx_q;

endmodule : mem_cmd_fsm

//--- main_mem.sv
// **************************************************************************
// main memory top level
// **************************************************************************

`timescale 1ns/1ps

module main_mem (
    input  logic                clk,
    input  logic                rst,

    // cache side request
    input  logic                i_req,
    input  logic                i_w_en,
    input  mem_pkg::mem_addr_t  i_addr,
    input  mem_pkg::mem_line_t  i_w_data,

    // cache side response
    output logic                o_ack,
    output mem_pkg::mem_line_t  o_r_data
);

    // sequencer to timer
    logic                   timer_start;
    logic                   timer_done;

    // sequencer to line store
    logic                   wr_stb;
    logic                   rd_stb;
    mem_pkg::mem_line_idx_t line_idx;

    // request sequencer
    mem_cmd_fsm cmd_fsm_i (
        .clk           (clk),
        .rst           (rst),
        .i_req         (i_req),
        .i_w_en        (i_w_en),
        .i_addr        (i_addr),
        .i_timer_done  (timer_done),
        .o_timer_start (timer_start),
        .o_wr_stb      (wr_stb),
        .o_rd_stb      (rd_stb),
        .o_line_idx    (line_idx),
        .o_ack         (o_ack)
    );

    // fixed access latency
    mem_access_timer access_timer_i (
        .clk     (clk),
        .rst     (rst),
        .i_start (timer_start),
        .o_done  (timer_done)
    );

    // write data comes straight from the port
    // read line goes straight back out
    mem_line_store line_store_i (
        .clk        (clk),
        .i_wr_stb   (wr_stb),
        .i_rd_stb   (rd_stb),
        .i_line_idx (line_idx),
        .i_w_data   (i_w_data),
        .o_r_data   (o_r_data)
    );

endmodule : main_mem

//--- main_mem_props.sv
// **************************************************************************
// main memory handshake assertions
// **************************************************************************

`timescale 1ns/1ps

module main_mem_props (
    input logic clk,
    input logic rst,
    input logic i_req,
    input logic o_ack
);

    // assertion failures so far
    int unsigned fail_count = 0;

    // ack only answers a request that is still held
    ack_needs_req: assert property (
        @(posedge clk) disable iff (rst) o_ack |-> i_req
    ) else begin
        fail_count++;
        $error("o_ack high while i_req low");
    end

    // single cycle pulse
    ack_one_cycle: assert property (
        @(posedge clk) disable iff (rst) o_ack |=> !o_ack
    ) else begin
        fail_count++;
        $error("o_ack high for two cycles in a row");
    end

    // nothing pending when reset ends
    ack_low_after_reset: assert property (
        @(posedge clk) $fell(rst) |-> !o_ack
    ) else begin
        fail_count++;
        $error("o_ack high in the cycle after reset release");
    end

endmodule : main_mem_props

// attach to every main_mem instance
bind main_mem main_mem_props props_i (
    .clk   (clk),
    .rst   (rst),
    .i_req (i_req),
    .o_ack (o_ack)
);

//--- tb_main_mem.sv
// **************************************************************************
// main memory directed testbench
// **************************************************************************

`timescale 1ns/1ps

`include "mem_defines.svh"

module tb_main_mem;

    // limit for every wait on the acknowledge
    localparam int ACK_TIMEOUT = 20;
    // edge that samples the request up to the ack cycle
    localparam int EXP_LATENCY = `MEM_ACCESS_CYCLES + 2;

    logic               clk;
    logic               rst;
    logic               i_req;
    logic               i_w_en;
    mem_pkg::mem_addr_t i_addr;
    mem_pkg::mem_line_t i_w_data;
    logic               o_ack;
    mem_pkg::mem_line_t o_r_data;

    // expected line contents where the last write wins
    mem_pkg::mem_line_t ref_mem [mem_pkg::mem_line_idx_t];
    logic [31:0]        rng_state;
    int                 n_checks;
    int                 n_errors;
    int                 n_tests;
    int                 n_failed_tests;

    main_mem dut_i (
        .clk      (clk),
        .rst      (rst),
        .i_req    (i_req),
        .i_w_en   (i_w_en),
        .i_addr   (i_addr),
        .i_w_data (i_w_data),
        .o_ack    (o_ack),
        .o_r_data (o_r_data)
    );

    // 20 ns clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // xorshift32 step
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // four random words with word 0 in the low bits
    function automatic mem_pkg::mem_line_t rand_line();
        mem_pkg::mem_line_t line;
        for (int w = 0; w < `MEM_WORDS_PER_LINE; w++) begin
            line[w*`MEM_WORD_W +: `MEM_WORD_W] = next_rand();
        end
        return line;
    endfunction

    task automatic check_line(input string name, input mem_pkg::mem_line_t exp,
                              input mem_pkg::mem_line_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        n_checks++;
        if (act != exp) begin
            n_errors++;
            $display("mismatch at %0t: %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    // one full request
    // lat counts edges from the sampling edge to the ack cycle
    task automatic mem_access(input logic wr, input mem_pkg::mem_addr_t addr,
                              input mem_pkg::mem_line_t wdata,
                              output mem_pkg::mem_line_t rdata, output int lat);
        @(posedge clk);
        i_req    <= 1'b1;
        i_w_en   <= wr;
        i_addr   <= addr;
        i_w_data <= wdata;
        // edge that samples the request
        @(posedge clk);
        lat = 0;
        @(negedge clk);
        while (!o_ack && lat < ACK_TIMEOUT) begin
            @(posedge clk);
            lat++;
            @(negedge clk);
        end
        if (!o_ack) begin
            $display("timeout: no acknowledge within %0d cycles at %0t", ACK_TIMEOUT, $time);
            $display(">>> FAIL");
            $finish;
        end
        rdata = o_r_data;
        // drop the request right after the ack
        @(posedge clk);
        i_req  <= 1'b0;
        i_w_en <= 1'b0;
        // ack must be a one cycle pulse
        @(negedge clk);
        check_bit("o_ack", 1'b0, o_ack);
    endtask

    task automatic write_line(input mem_pkg::mem_addr_t addr, input mem_pkg::mem_line_t data);
        mem_pkg::mem_line_t unused;
        int                 lat;
        mem_access(1'b1, addr, data, unused, lat);
        ref_mem[mem_pkg::mem_line_idx_t'(addr >> 4)] = data;
    endtask

    task automatic read_check(input mem_pkg::mem_addr_t addr);
        mem_pkg::mem_line_t got;
        int                 lat;
        mem_access(1'b0, addr, '0, got, lat);
        check_line("o_r_data", ref_mem[mem_pkg::mem_line_idx_t'(addr >> 4)], got);
    endtask

    task automatic end_test(input string name, input int err_before);
        n_tests++;
        if (n_errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            n_failed_tests++;
            $display("test %s: failed with %0d errors", name, n_errors - err_before);
        end
    endtask

    // ack quiet after reset and while idle
    task automatic test_idle_ack();
        int err_before;
        err_before = n_errors;
        for (int c = 0; c < 8; c++) begin
            @(negedge clk);
            check_bit("o_ack", 1'b0, o_ack);
        end
        write_line(12'h100, rand_line());
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            check_bit("o_ack", 1'b0, o_ack);
        end
        end_test("idle_ack", err_before);
    endtask

    task automatic test_write_read();
        int err_before;
        err_before = n_errors;
        write_line(12'h210, rand_line());
        write_line(12'h3f0, rand_line());
        read_check(12'h210);
        read_check(12'h3f0);
        end_test("write_read", err_before);
    endtask

    // byte offset bits must not change the line
    task automatic test_offset_alias();
        int err_before;
        err_before = n_errors;
        write_line(12'h5a7, rand_line());
        read_check(12'h5a0);
        read_check(12'h5ac);
        read_check(12'h5af);
        end_test("offset_alias", err_before);
    endtask

    task automatic test_latency();
        mem_pkg::mem_line_t data;
        mem_pkg::mem_line_t got;
        int                 err_before;
        int                 lat;
        err_before = n_errors;
        data = rand_line();
        mem_access(1'b1, 12'h7c0, data, got, lat);
        ref_mem[8'h7c] = data;
        check_count("write latency", EXP_LATENCY, lat);
        mem_access(1'b0, 12'h7c0, '0, got, lat);
        check_count("read latency", EXP_LATENCY, lat);
        check_line("o_r_data", data, got);
        end_test("latency", err_before);
    endtask

    // mixed writes and reads of written lines
    task automatic test_random_sweep();
        mem_pkg::mem_line_idx_t written[$];
        mem_pkg::mem_line_idx_t idx;
        logic [31:0]            r;
        int                     err_before;
        err_before = n_errors;
        for (int op = 0; op < 40; op++) begin
            r = next_rand();
            if (written.size() == 0 || r[0]) begin
                // few distinct lines so rewrites happen
                idx = mem_pkg::mem_line_idx_t'(r[11:8] | 8'h80);
                write_line({idx, r[15:12]}, rand_line());
                written.push_back(idx);
            end else begin
                idx = written[r[31:16] % written.size()];
                read_check({idx, r[7:4]});
            end
        end
        end_test("random_sweep", err_before);
    endtask

    initial begin
        rst            = 1'b1;
        i_req          = 1'b0;
        i_w_en         = 1'b0;
        i_addr         = '0;
        i_w_data       = '0;
        rng_state      = 32'd96835;
        n_checks       = 0;
        n_errors       = 0;
        n_tests        = 0;
        n_failed_tests = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        test_idle_ack();
        test_write_read();
        test_offset_alias();
        test_latency();
        test_random_sweep();

        $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 n_tests, n_failed_tests, n_checks, n_errors, dut_i.props_i.fail_count);
        if (n_errors == 0 && dut_i.props_i.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule : tb_main_mem

//--- build.f
+incdir+.
mem_pkg.sv
mem_access_timer.sv
mem_line_store.sv
mem_cmd_fsm.sv
main_mem.sv
main_mem_props.sv
tb_main_mem.sv

//--- Bender.yml
package:
  name: main_mem

export_include_dirs:
  - .

sources:
  - mem_pkg.sv
  - mem_access_timer.sv
  - mem_line_store.sv
  - mem_cmd_fsm.sv
  - main_mem.sv
  - target: test
    files:
      - main_mem_props.sv
      - tb_main_mem.sv
